// ==== hdl/conv_pkg.sv ====
// Convolution engine constants
`default_nettype none

package conv_pkg;

    // Data widths
    localparam int PIX_W  = 16;
    localparam int COEF_W = 16;
    localparam int ACC_W  = 48;

    // Frame geometry
    localparam int IMG_SIZE = 8;
    localparam int CNT_W    = 3;

    // Nine coefficients then the bias word
    localparam int N_KWORDS = 10;

    // Valid positions only, no padding
    localparam int OUT_PER_FRAME = (IMG_SIZE - 2) * (IMG_SIZE - 2);

    // Window strobe to result, in cycles
    localparam int MAC_LAT = 3;

    // Result FIFO sizing
    localparam int FIFO_DEPTH = 8;
    // Level must reach FIFO_DEPTH itself
    localparam int LVL_W      = 4;

endpackage

`default_nettype wire

// ==== hdl/conv_ctrl.sv ====
// Convolution control unit
`timescale 1ns/1ps
`default_nettype none

module conv_ctrl (
    input  logic                         clk,
    input  logic                         arst_n,
    // Kernel stream handshake
    input  logic                         k_tvalid,
    output logic                         k_tready,
    // Pixel stream handshake
    input  logic                         s_tvalid,
    input  logic                         s_tlast,
    output logic                         s_tready,
    // Result FIFO occupancy
    input  logic [conv_pkg::LVL_W-1:0]   level,
    // Datapath controls
    output logic                         coef_wr,
    output logic                         pix_acc,
    output logic [conv_pkg::CNT_W-1:0]   col,
    output logic                         win_valid,
    output logic                         win_last
);

    // Low while loading the kernel
    logic                                  run;
    logic [$clog2(conv_pkg::N_KWORDS)-1:0] kcnt;
    logic [conv_pkg::CNT_W-1:0]            row;
    // Mirror of the MAC valid stages
    logic [conv_pkg::MAC_LAT-1:0]          flight;
    logic [conv_pkg::LVL_W:0]              inflight;
    logic [conv_pkg::LVL_W:0]              credit;
    logic                                  last_pos;
    logic                                  col_end;
    logic                                  win_pos;

    // Kernel load handshake
    assign k_tready = !run;
    assign coef_wr  = k_tvalid && k_tready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run  <= 1'b0;
            kcnt <= '0;
        end else if (coef_wr) begin
            // Tenth word is the bias
            if (kcnt == ($clog2(conv_pkg::N_KWORDS))'(conv_pkg::N_KWORDS - 1)) begin
                run <= 1'b1;
            end
            kcnt <= kcnt + 1'b1;
        end
    end

    // Results that will land in the FIFO but are not yet counted
    always_comb begin
        inflight = {{conv_pkg::LVL_W{1'b0}}, win_valid};
        for (int i = 0; i < conv_pkg::MAC_LAT; i++) begin
            inflight = inflight + {{conv_pkg::LVL_W{1'b0}}, flight[i]};
        end
    end

    assign credit = {1'b0, level} + inflight;

    // Accept only if one more result still fits
    assign s_tready = run && (credit < (conv_pkg::LVL_W + 1)'(conv_pkg::FIFO_DEPTH));
    assign pix_acc  = s_tvalid && s_tready;

    // Position decode
    assign col_end  = (col == (conv_pkg::CNT_W)'(conv_pkg::IMG_SIZE - 1));
    assign last_pos = col_end && (row == (conv_pkg::CNT_W)'(conv_pkg::IMG_SIZE - 1));
    assign win_pos  = (row >= (conv_pkg::CNT_W)'(2)) && (col >= (conv_pkg::CNT_W)'(2));

    // Raster counters
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row <= '0;
            col <= '0;
        end else if (pix_acc) begin
            if (s_tlast || last_pos) begin
                // Frame end, or realign on an early s_tlast
                row <= '0;
                col <= '0;
            end else if (col_end) begin
                col <= '0;
                row <= row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // Window strobe one cycle after the pixel
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            win_valid <= 1'b0;
            win_last  <= 1'b0;
            flight    <= '0;
        end else begin
            win_valid <= pix_acc && win_pos;
            win_last  <= pix_acc && last_pos;
            flight    <= {flight[conv_pkg::MAC_LAT-2:0], win_valid};
        end
    end

endmodule

`default_nettype wire

// ==== hdl/line_buffer.sv ====
// One-row pixel delay line
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
    input  logic                         clk,
    // Write strobe, one per accepted pixel
    input  logic                         pix_acc,
    // Column address shared with the counters
    input  logic [conv_pkg::CNT_W-1:0]   col,
    input  logic [conv_pkg::PIX_W-1:0]   din,
    output logic [conv_pkg::PIX_W-1:0]   dout
);

    // One entry per column
    logic [conv_pkg::PIX_W-1:0] mem [conv_pkg::IMG_SIZE];

    // Old entry visible before the overwrite
    assign dout = mem[col];

    // Same column from one row back is replaced
    always_ff @(posedge clk) begin
        if (pix_acc) begin
            mem[col] <= din;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/window_3x3.sv ====
// 3x3 pixel window register
`timescale 1ns/1ps
`default_nettype none

module window_3x3 (
    input  logic                           clk,
    input  logic                           arst_n,
    // Shift strobe
    input  logic                           pix_acc,
    // Newest column, one pixel per row
    input  logic [conv_pkg::PIX_W-1:0]     row_n,
    input  logic [conv_pkg::PIX_W-1:0]     row_n_1,
    input  logic [conv_pkg::PIX_W-1:0]     row_n_2,
    // w00 in the top bits, w22 in the bottom bits
    output logic [9*conv_pkg::PIX_W-1:0]   win
);

    // w[r][c], row 0 is the oldest row, col 2 the newest column
    logic [conv_pkg::PIX_W-1:0] w [3][3];
    logic [conv_pkg::PIX_W-1:0] col_in [3];

    // Oldest row on top
    assign col_in[0] = row_n_2;
    assign col_in[1] = row_n_1;
    assign col_in[2] = row_n;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < 3; r++) begin
                for (int c = 0; c < 3; c++) begin
                    w[r][c] <= '0;
                end
            end
        end else if (pix_acc) begin
            // Shift left and load the right column
            for (int r = 0; r < 3; r++) begin
                w[r][0] <= w[r][1];
                w[r][1] <= w[r][2];
                w[r][2] <= col_in[r];
            end
        end
    end

    // Row-major flatten
    for (genvar r = 0; r < 3; r++) begin : g_row
        for (genvar c = 0; c < 3; c++) begin : g_col
            assign win[(8 - (r * 3 + c)) * conv_pkg::PIX_W +: conv_pkg::PIX_W] = w[r][c];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/conv_mac.sv ====
// 3x3 multiply-accumulate pipeline
`timescale 1ns/1ps
`default_nettype none

module conv_mac (
    input  logic                           clk,
    input  logic                           arst_n,
    // Kernel word load
    input  logic                           coef_wr,
    input  logic [conv_pkg::COEF_W-1:0]    coef,
    // Window, w00 in the top bits
    input  logic [9*conv_pkg::PIX_W-1:0]   win,
    input  logic                           win_valid,
    input  logic                           win_last,
    // Result, three cycles after win_valid
    output logic                           res_valid,
    output logic [conv_pkg::ACC_W-1:0]     res_data,
    output logic                           res_last
);

    // k00..k22 then the bias
    logic signed [conv_pkg::COEF_W-1:0]                 kreg [conv_pkg::N_KWORDS];
    logic signed [conv_pkg::PIX_W+conv_pkg::COEF_W-1:0] prod [9];
    logic signed [conv_pkg::ACC_W-1:0]                  tree_sum;
    logic signed [conv_pkg::ACC_W-1:0]                  sum_q;
    // Flags riding with each stage
    logic                                               v1;
    logic                                               v2;
    logic                                               l1;
    logic                                               l2;

    // Shift chain, first word ends at k00
    always_ff @(posedge clk) begin
        if (coef_wr) begin
            for (int i = 0; i < conv_pkg::N_KWORDS - 1; i++) begin
                kreg[i] <= kreg[i + 1];
            end
            kreg[conv_pkg::N_KWORDS - 1] <= coef;
        end
    end

    // Stage 1: nine signed products
    always_ff @(posedge clk) begin
        for (int i = 0; i < 9; i++) begin
            prod[i] <= $signed(win[(8 - i) * conv_pkg::PIX_W +: conv_pkg::PIX_W]) * kreg[i];
        end
    end

    // Sign-extended sum of products
    always_comb begin
        tree_sum = '0;
        for (int i = 0; i < 9; i++) begin
            tree_sum = tree_sum + prod[i];
        end
    end

    // Stage 2 sum, stage 3 bias
    always_ff @(posedge clk) begin
        sum_q    <= tree_sum;
        res_data <= sum_q + kreg[conv_pkg::N_KWORDS - 1];
    end

    // Valid and last pipeline
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            v1        <= 1'b0;
            v2        <= 1'b0;
            res_valid <= 1'b0;
            l1        <= 1'b0;
            l2        <= 1'b0;
            res_last  <= 1'b0;
        end else begin
            v1        <= win_valid;
            v2        <= v1;
            res_valid <= v2;
            l1        <= win_last;
            l2        <= l1;
            res_last  <= l2;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/result_fifo.sv ====
// Result FIFO with last flag
`timescale 1ns/1ps
`default_nettype none

module result_fifo #(
    parameter int DEPTH = conv_pkg::FIFO_DEPTH
) (
    input  logic                         clk,
    input  logic                         arst_n,
    // Write side from the MAC
    input  logic                         wr_valid,
    input  logic [conv_pkg::ACC_W-1:0]   wr_data,
    input  logic                         wr_last,
    // Master stream
    input  logic                         m_tready,
    output logic                         m_tvalid,
    output logic [conv_pkg::ACC_W-1:0]   m_tdata,
    output logic                         m_tlast,
    // Occupancy for the credit check
    output logic [conv_pkg::LVL_W-1:0]   level
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    // Last flag stored above the data
    logic [conv_pkg::ACC_W:0] mem [DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic                     wr_en;
    logic                     rd_en;

    assign wr_en    = wr_valid && (level != (conv_pkg::LVL_W)'(DEPTH));
    assign rd_en    = m_tvalid && m_tready;
    // Head entry
    assign m_tvalid = (level != '0);
    assign m_tdata  = mem[rd_ptr][conv_pkg::ACC_W-1:0];
    assign m_tlast  = mem[rd_ptr][conv_pkg::ACC_W];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {wr_last, wr_data};
        end
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == (PTR_W)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == (PTR_W)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write keeps the level
            if (wr_en && !rd_en) begin
                level <= level + 1'b1;
            end else if (rd_en && !wr_en) begin
                level <= level - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/conv_top.sv ====
// Streaming 3x3 convolution top level
`timescale 1ns/1ps
`default_nettype none

module conv_top (
    input  logic                         clk,
    input  logic                         arst_n,
    // Kernel stream, nine coefficients then bias
    input  logic [conv_pkg::COEF_W-1:0]  k_tdata,
    input  logic                         k_tvalid,
    output logic                         k_tready,
    // Pixel stream, raster order
    input  logic [conv_pkg::PIX_W-1:0]   s_tdata,
    input  logic                         s_tvalid,
    output logic                         s_tready,
    input  logic                         s_tlast,
    // Result stream
    output logic [conv_pkg::ACC_W-1:0]   m_tdata,
    output logic                         m_tvalid,
    input  logic                         m_tready,
    output logic                         m_tlast
);

    // Control unit outputs
    logic                         coef_wr;
    logic                         pix_acc;
    logic [conv_pkg::CNT_W-1:0]   col;
    logic                         win_valid;
    logic                         win_last;

    // Line buffer rows
    logic [conv_pkg::PIX_W-1:0]   row_n_1;
    logic [conv_pkg::PIX_W-1:0]   row_n_2;

    // Window to MAC
    logic [9*conv_pkg::PIX_W-1:0] win;

    // MAC to FIFO
    logic                         res_valid;
    logic [conv_pkg::ACC_W-1:0]   res_data;
    logic                         res_last;
    logic [conv_pkg::LVL_W-1:0]   level;

    conv_ctrl u_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .k_tvalid  (k_tvalid),
        .k_tready  (k_tready),
        .s_tvalid  (s_tvalid),
        .s_tlast   (s_tlast),
        .s_tready  (s_tready),
        .level     (level),
        .coef_wr   (coef_wr),
        .pix_acc   (pix_acc),
        .col       (col),
        .win_valid (win_valid),
        .win_last  (win_last)
    );

    // Row n-1 from the incoming pixel
    line_buffer line_buffer_n_1 (
        .clk     (clk),
        .pix_acc (pix_acc),
        .col     (col),
        .din     (s_tdata),
        .dout    (row_n_1)
    );

    // Row n-2 chained from row n-1
    line_buffer line_buffer_n_2 (
        .clk     (clk),
        .pix_acc (pix_acc),
        .col     (col),
        .din     (row_n_1),
        .dout    (row_n_2)
    );

    window_3x3 u_window (
        .clk     (clk),
        .arst_n  (arst_n),
        .pix_acc (pix_acc),
        .row_n   (s_tdata),
        .row_n_1 (row_n_1),
        .row_n_2 (row_n_2),
        .win     (win)
    );

    // Kernel words go straight to the MAC chain
    conv_mac u_mac (
        .clk       (clk),
        .arst_n    (arst_n),
        .coef_wr   (coef_wr),
        .coef      (k_tdata),
        .win       (win),
        .win_valid (win_valid),
        .win_last  (win_last),
        .res_valid (res_valid),
        .res_data  (res_data),
        .res_last  (res_last)
    );

    result_fifo #(
        .DEPTH (conv_pkg::FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .arst_n   (arst_n),
        .wr_valid (res_valid),
        .wr_data  (res_data),
        .wr_last  (res_last),
        .m_tready (m_tready),
        .m_tvalid (m_tvalid),
        .m_tdata  (m_tdata),
        .m_tlast  (m_tlast),
        .level    (level)
    );

endmodule

`default_nettype wire

// ==== sim/tb_clk_gen.sv ====
// Clock and reset source
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    // 40 ns period
    localparam int HALF_NS    = 20;
    localparam int RST_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_NS) clk = ~clk;
        end
    end

    // Real falling edge so the async resets fire
    initial begin
        arst_n = 1'b1;
        #5 arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== sim/conv_sva.sv ====
// Stream protocol checks for conv_top
`timescale 1ns/1ps
`default_nettype none

module conv_sva_chk (
    input logic                         clk,
    input logic                         arst_n,
    input logic                         s_tvalid,
    input logic                         s_tready,
    input logic                         s_tlast,
    input logic [conv_pkg::ACC_W-1:0]   m_tdata,
    input logic                         m_tvalid,
    input logic                         m_tready,
    input logic                         m_tlast,
    // FIFO occupancy inside the top level
    input logic [conv_pkg::LVL_W-1:0]   level
);

    localparam int PCNT_W = $clog2(conv_pkg::IMG_SIZE * conv_pkg::IMG_SIZE);

    // Accepted pixels within the current frame
    logic [PCNT_W-1:0] pix_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pix_cnt <= '0;
        end else if (s_tvalid && s_tready) begin
            pix_cnt <= pix_cnt + (PCNT_W)'(1);
        end
    end

    // Stalled result holds its payload
    a_m_hold: assert property (@(posedge clk) disable iff (!arst_n)
        (m_tvalid && !m_tready) |=> (m_tvalid && $stable(m_tdata) && $stable(m_tlast)))
        else $error("result stream changed while stalled");

    // Full FIFO blocks the pixel stream
    a_full_block: assert property (@(posedge clk) disable iff (!arst_n)
        (level == (conv_pkg::LVL_W)'(conv_pkg::FIFO_DEPTH)) |-> !s_tready)
        else $error("pixel accepted with the result FIFO full");

    // s_tlast on the 64th pixel only
    a_tlast_pos: assert property (@(posedge clk) disable iff (!arst_n)
        (s_tvalid && s_tready)
            |-> (s_tlast == (pix_cnt == (PCNT_W)'(conv_pkg::IMG_SIZE * conv_pkg::IMG_SIZE - 1))))
        else $error("s_tlast not aligned with the frame end");

endmodule

bind conv_top conv_sva_chk u_sva (
    .clk      (clk),
    .arst_n   (arst_n),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .s_tlast  (s_tlast),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast),
    .level    (level)
);

`default_nettype wire

// ==== sim/conv_tb.sv ====
// Convolution engine testbench
`timescale 1ns/1ps
`default_nettype none

module conv_tb;

    localparam logic [31:0] SEED = 32'h63b21951;
    // Kernel load plus 3 x 64 pixels, x4 for gaps and stalls, plus margin
    localparam int TIMEOUT  = 3000;
    localparam int N_FRAMES = 3;
    localparam int SIDE     = conv_pkg::IMG_SIZE;
    localparam int N_PIX    = SIDE * SIDE;
    localparam int N_OUT    = N_FRAMES * conv_pkg::OUT_PER_FRAME;
    localparam int N_KW     = conv_pkg::N_KWORDS;
    localparam int PAT_LEN  = 512;

    logic                         clk;
    logic                         arst_n;
    logic [conv_pkg::COEF_W-1:0]  k_tdata;
    logic                         k_tvalid;
    logic                         k_tready;
    logic [conv_pkg::PIX_W-1:0]   s_tdata;
    logic                         s_tvalid;
    logic                         s_tready;
    logic                         s_tlast;
    logic [conv_pkg::ACC_W-1:0]   m_tdata;
    logic                         m_tvalid;
    logic                         m_tready = 1'b0;
    logic                         m_tlast;

    // Stimulus tables, filled at time zero
    logic [31:0]                  lfsr;
    logic [conv_pkg::COEF_W-1:0]  kern [N_KW];
    logic [conv_pkg::PIX_W-1:0]   pix [N_FRAMES][N_PIX];
    int                           gap [N_FRAMES][N_PIX];
    logic                         fast_pat [PAT_LEN];
    logic                         slow_pat [PAT_LEN];
    // Reference results in raster order
    logic [conv_pkg::ACC_W-1:0]   exp_q [$];

    int cycle_cnt     = 0;
    int cur_frame     = 0;
    int kwords        = 0;
    int out_cnt       = 0;
    int value_errs    = 0;
    int framing_errs  = 0;
    int protocol_errs = 0;
    int end_errs      = 0;

    tb_clk_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    conv_top UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .k_tdata  (k_tdata),
        .k_tvalid (k_tvalid),
        .k_tready (k_tready),
        .s_tdata  (s_tdata),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .m_tdata  (m_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
    endtask

    task automatic make_tables();
        logic [31:0] b;
        logic        blk;
        blk = 1'b1;
        // Small signed coefficients, -16 to 15
        for (int i = 0; i < N_KW - 1; i++) begin
            take_bits(5, b);
            kern[i] = {{(conv_pkg::COEF_W - 5){b[4]}}, b[4:0]};
        end
        // Full-range bias word
        take_bits(conv_pkg::COEF_W, b);
        kern[N_KW - 1] = b[conv_pkg::COEF_W-1:0];
        for (int f = 0; f < N_FRAMES; f++) begin
            for (int p = 0; p < N_PIX; p++) begin
                take_bits(conv_pkg::PIX_W, b);
                pix[f][p] = b[conv_pkg::PIX_W-1:0];
                take_bits(2, b);
                gap[f][p] = (b[1:0] == 2'b00) ? 3 : ((b[1:0] == 2'b01) ? 1 : 0);
            end
        end
        for (int i = 0; i < PAT_LEN; i++) begin
            take_bits(2, b);
            fast_pat[i] = (b[1:0] != 2'b00);
            // Slow mode goes dark for whole 16-cycle blocks
            if (i % 16 == 0) begin
                take_bits(1, b);
                blk = b[0];
            end
            take_bits(1, b);
            slow_pat[i] = blk && b[0];
        end
    endtask

    // Valid positions of one frame, raster order
    task automatic push_expected(input int f);
        longint acc;
        for (int r = 0; r <= SIDE - 3; r++) begin
            for (int c = 0; c <= SIDE - 3; c++) begin
                acc = longint'($signed(kern[N_KW - 1]));
                for (int i = 0; i < 3; i++) begin
                    for (int j = 0; j < 3; j++) begin
                        acc = acc + longint'($signed(kern[i * 3 + j]))
                            * longint'($signed(pix[f][(r + i) * SIDE + c + j]));
                    end
                end
                exp_q.push_back(acc[conv_pkg::ACC_W-1:0]);
            end
        end
    endtask

    // Cycle counter and result-side back-pressure
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cur_frame == 1) begin
            m_tready <= slow_pat[cycle_cnt % PAT_LEN];
        end else begin
            m_tready <= fast_pat[cycle_cnt % PAT_LEN];
        end
    end

    // Handshake and result checks on pre-edge values
    always @(posedge clk) begin
        logic [conv_pkg::ACC_W-1:0] expv;
        logic                       exp_last;
        if (!arst_n) begin
            assert (k_tready && !s_tready && !m_tvalid) else begin
                $display("FAIL reset_handshake expected k/s/m 100 actual %0b%0b%0b",
                    k_tready, s_tready, m_tvalid);
                protocol_errs++;
            end
        end else begin
            // Pixel side closed until the bias is in
            if (kwords < N_KW) begin
                assert (!s_tready) else begin
                    $display("FAIL load_s_tready expected 0 actual %0b", s_tready);
                    protocol_errs++;
                end
            end else begin
                assert (!k_tready) else begin
                    $display("FAIL run_k_tready expected 0 actual %0b", k_tready);
                    protocol_errs++;
                end
            end
            if (k_tvalid && k_tready) begin
                kwords <= kwords + 1;
            end
            if (m_tvalid && m_tready) begin
                if (exp_q.size() == 0) begin
                    $display("Result %0d arrived with no reference value pending", out_cnt);
                    value_errs++;
                end else begin
                    expv     = exp_q.pop_front();
                    exp_last = ((out_cnt % conv_pkg::OUT_PER_FRAME)
                        == conv_pkg::OUT_PER_FRAME - 1);
                    assert (m_tdata == expv) else begin
                        $display("FAIL conv_value[%0d] expected %0d actual %0d",
                            out_cnt, $signed(expv), $signed(m_tdata));
                        value_errs++;
                    end
                    assert (m_tlast == exp_last) else begin
                        $display("FAIL frame_last[%0d] expected %0b actual %0b",
                            out_cnt, exp_last, m_tlast);
                        framing_errs++;
                    end
                end
                out_cnt <= out_cnt + 1;
            end
        end
    end

    // Hang guard
    initial begin
        wait (cycle_cnt >= TIMEOUT);
        $display("Timeout after %0d cycles with %0d of %0d results received",
            cycle_cnt, out_cnt, N_OUT);
        $display("Errors found");
        $finish;
    end

    initial begin
        k_tdata  = '0;
        k_tvalid = 1'b0;
        s_tdata  = '0;
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        lfsr     = SEED;
        make_tables();
        @(posedge clk);
        while (!arst_n) begin
            @(posedge clk);
        end
        // Nine coefficients then bias
        for (int w = 0; w < N_KW; w++) begin
            k_tdata  <= kern[w];
            k_tvalid <= 1'b1;
            @(posedge clk);
            while (!k_tready) begin
                @(posedge clk);
            end
        end
        k_tvalid <= 1'b0;
        for (int f = 0; f < N_FRAMES; f++) begin
            push_expected(f);
            cur_frame <= f;
            for (int p = 0; p < N_PIX; p++) begin
                if (gap[f][p] > 0) begin
                    s_tvalid <= 1'b0;
                    s_tlast  <= 1'b0;
                    repeat (gap[f][p]) @(posedge clk);
                end
                s_tdata  <= pix[f][p];
                s_tvalid <= 1'b1;
                s_tlast  <= (p == N_PIX - 1);
                @(posedge clk);
                while (!s_tready) begin
                    @(posedge clk);
                end
            end
        end
        s_tvalid <= 1'b0;
        s_tlast  <= 1'b0;
        while (out_cnt < N_OUT) begin
            @(posedge clk);
        end
        // Room for any duplicate to surface
        repeat (20) @(posedge clk);
        assert (out_cnt == N_OUT) else begin
            $display("FAIL result_count expected %0d actual %0d", N_OUT, out_cnt);
            end_errs++;
        end
        assert (!m_tvalid) else begin
            $display("Extra result still offered after the last frame");
            end_errs++;
        end
        $display("Error counts: value %0d, framing %0d, protocol %0d, end of run %0d",
            value_errs, framing_errs, protocol_errs, end_errs);
        if (value_errs + framing_errs + protocol_errs + end_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/conv_pkg.sv
hdl/conv_ctrl.sv
hdl/line_buffer.sv
hdl/window_3x3.sv
hdl/conv_mac.sv
hdl/result_fifo.sv
hdl/conv_top.sv
sim/tb_clk_gen.sv
sim/conv_sva.sv
sim/conv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the convolution engine simulation with Verilator.
# The run counts as passed only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f flist.f --top-module conv_tb -o conv_sim \
    && ./obj_dir/conv_sim | tee sim.log \
    && grep -q "^No errors$" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
